// ==== include/psr_settings.svh ====
`ifndef PSR_SETTINGS_SVH
`define PSR_SETTINGS_SVH

// Status word layout
`define PSR_WIDTH 12
`define MODE_WIDTH 5
`define PSR_I_BIT 7                      // IRQ mask
`define PSR_F_BIT 6                      // FIQ mask
`define PSR_RESET 12'h0D3                // Svc mode, I and F set, flags clear

// Processor modes
`define MODE_USR 5'b10000
`define MODE_FIQ 5'b10001
`define MODE_IRQ 5'b10010
`define MODE_SVC 5'b10011
`define MODE_ABT 5'b10111
`define MODE_UND 5'b11011
`define MODE_SYS 5'b11111

// SPSR banks, in address order
`define BANK_WIDTH 3
`define SPSR_BANKS 5
`define BANK_SVC 3'd0
`define BANK_ABT 3'd1
`define BANK_UND 3'd2
`define BANK_IRQ 3'd3
`define BANK_FIQ 3'd4

// Vector byte offsets
`define VEC_WIDTH 5
`define VEC_UND 5'h04
`define VEC_SWI 5'h08
`define VEC_PABT 5'h0C
`define VEC_DABT 5'h10
`define VEC_IRQ 5'h18
`define VEC_FIQ 5'h1C

`define IRQ_LINES 8                      // External interrupt inputs

// APB register map
`define APB_ADDR_WIDTH 6
`define APB_DATA_WIDTH 32
`define ADDR_CPSR 6'h00
`define ADDR_SPSR_BASE 6'h04             // Svc bank, then abt, und, irq, fiq
`define ADDR_SPSR_LAST 6'h14             // Fiq bank
`define ADDR_IRQ_ENABLE 6'h20
`define ADDR_IRQ_PENDING 6'h24
`define ADDR_FIQ_SELECT 6'h28

`endif

// ==== logic/psrPkg.sv ====
`default_nettype none

`include "psr_settings.svh"

package psrPkg;

  // Status word
  // [11:8] NZCV, [7] I, [6] F, [5] reserved, [4:0] mode
  typedef logic [`PSR_WIDTH-1:0] statusWord;

  typedef logic [`MODE_WIDTH-1:0] modeCode;      // Processor mode field

  typedef logic [`VEC_WIDTH-1:0] vectorOffset;   // Byte offset into vector table

  // Selects one of the saved status registers
  typedef logic [`BANK_WIDTH-1:0] bankIndex;

  // Host bus
  typedef logic [`APB_ADDR_WIDTH-1:0] apbAddr;
  typedef logic [`APB_DATA_WIDTH-1:0] apbData;

  // Exception kinds, highest rank first after none
  typedef enum logic [2:0] {
    kindNone,
    kindDataAbort,
    kindFiq,
    kindIrq,
    kindPrefetchAbort,
    kindUndefined,
    kindSoftwareInterrupt
  } exceptionKind;

endpackage

`default_nettype wire

// ==== logic/exceptionPrioritizer.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "psr_settings.svh"

module exceptionPrioritizer (
  input  logic                dataAbort,
  input  logic                fiqRequest,
  input  logic                irqRequest,
  input  logic                prefetchAbort,
  input  logic                undefinedInstr,
  input  logic                softwareInt,
  input  psrPkg::statusWord   currentPsr,
  output logic                takeException,
  output psrPkg::modeCode     targetMode,
  output psrPkg::bankIndex    targetBank,
  output psrPkg::vectorOffset targetVector
);
  import psrPkg::*;

  exceptionKind kind;
  modeCode currentMode;
  logic irqMasked;
  logic fiqMasked;

  assign currentMode = currentPsr[`MODE_WIDTH-1:0];
  assign irqMasked = currentPsr[`PSR_I_BIT];
  assign fiqMasked = currentPsr[`PSR_F_BIT];

  // Fixed ranking, a request into the mode already held is ignored
  always_comb begin
    kind = kindNone;
    if (dataAbort && currentMode != `MODE_ABT) begin
      kind = kindDataAbort;
    end else if (fiqRequest && !fiqMasked && currentMode != `MODE_FIQ) begin
      kind = kindFiq;
    end else if (irqRequest && !irqMasked && currentMode != `MODE_IRQ) begin
      kind = kindIrq;
    end else if (prefetchAbort && currentMode != `MODE_ABT) begin
      kind = kindPrefetchAbort;
    end else if (undefinedInstr && currentMode != `MODE_UND) begin
      kind = kindUndefined;
    end else if (softwareInt && currentMode != `MODE_SVC) begin
      kind = kindSoftwareInterrupt;
    end
  end

  assign takeException = (kind != kindNone);

  // Kind to mode, bank and vector
  always_comb begin
    targetMode = currentMode;        // Held when nothing is taken
    targetBank = `BANK_SVC;
    targetVector = '0;
    case (kind)
      kindDataAbort: begin
        targetMode = `MODE_ABT;
        targetBank = `BANK_ABT;
        targetVector = `VEC_DABT;
      end
      kindFiq: begin
        targetMode = `MODE_FIQ;
        targetBank = `BANK_FIQ;
        targetVector = `VEC_FIQ;
      end
      kindIrq: begin
        targetMode = `MODE_IRQ;
        targetBank = `BANK_IRQ;
        targetVector = `VEC_IRQ;
      end
      kindPrefetchAbort: begin
        targetMode = `MODE_ABT;      // Shares abt bank with data abort
        targetBank = `BANK_ABT;
        targetVector = `VEC_PABT;
      end
      kindUndefined: begin
        targetMode = `MODE_UND;
        targetBank = `BANK_UND;
        targetVector = `VEC_UND;
      end
      kindSoftwareInterrupt: begin
        targetMode = `MODE_SVC;
        targetBank = `BANK_SVC;
        targetVector = `VEC_SWI;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/statusRegisters.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "psr_settings.svh"

module statusRegisters (
  input  logic                clk,
  input  logic                reset,
  input  logic                takeException,
  input  logic                restore,
  input  logic                flagsEnable,
  input  logic                cpsrSel,
  input  logic                pwrite,
  input  psrPkg::modeCode     targetMode,
  input  psrPkg::bankIndex    targetBank,
  input  psrPkg::vectorOffset targetVector,
  input  logic [3:0]          flagsNext,
  input  psrPkg::apbAddr      paddr,
  input  psrPkg::apbData      pwdata,
  output psrPkg::statusWord   cpsr,
  output psrPkg::apbData      cpsrRdata,
  output logic                exceptionTaken,
  output psrPkg::vectorOffset vectorAddress
);
  import psrPkg::*;

  statusWord spsr [`SPSR_BANKS];     // Svc, abt, und, irq, fiq
  statusWord entryWord;
  statusWord writeWord;
  bankIndex restoreBank;
  logic restoreValid;
  bankIndex apbBank;
  logic apbBankValid;
  logic cpsrWrite;
  logic spsrWrite;

  // New mode, I always set, F set only on FIQ entry, flags kept
  assign entryWord = {cpsr[`PSR_WIDTH-1:8], 1'b1,
                      cpsr[`PSR_F_BIT] | (targetMode == `MODE_FIQ),
                      1'b0, targetMode};

  // Host word with the reserved bit forced low
  assign writeWord = {pwdata[`PSR_WIDTH-1:6], 1'b0, pwdata[4:0]};

  // Bank of the current mode for restore
  always_comb begin
    restoreValid = 1'b1;
    restoreBank = `BANK_SVC;
    case (cpsr[`MODE_WIDTH-1:0])
      `MODE_SVC: restoreBank = `BANK_SVC;
      `MODE_ABT: restoreBank = `BANK_ABT;
      `MODE_UND: restoreBank = `BANK_UND;
      `MODE_IRQ: restoreBank = `BANK_IRQ;
      `MODE_FIQ: restoreBank = `BANK_FIQ;
      `MODE_USR, `MODE_SYS: restoreValid = 1'b0;   // No SPSR here
      default: restoreValid = 1'b0;
    endcase
  end

  // APB decode within the status range
  assign apbBank = bankIndex'((paddr - `ADDR_SPSR_BASE) >> 2);
  assign apbBankValid = (paddr >= `ADDR_SPSR_BASE) && (paddr <= `ADDR_SPSR_LAST)
                        && (paddr[1:0] == 2'b00);
  assign cpsrWrite = cpsrSel && pwrite && (paddr == `ADDR_CPSR);
  assign spsrWrite = cpsrSel && pwrite && apbBankValid;

  // CPSR, entry > restore > host write > flag update
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      cpsr <= `PSR_RESET;
    end else if (takeException) begin
      cpsr <= entryWord;
    end else if (restore && restoreValid) begin
      cpsr <= spsr[restoreBank];
    end else if (cpsrWrite) begin
      cpsr <= writeWord;
    end else if (flagsEnable) begin
      cpsr <= {flagsNext, cpsr[7:0]};      // NZCV only
    end
  end

  // Banked SPSRs, entry save wins over a host write to the same bank
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `SPSR_BANKS; i++) begin
        spsr[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `SPSR_BANKS; i++) begin
        if (takeException && targetBank == bankIndex'(i)) begin
          spsr[i] <= cpsr;                 // Old CPSR
        end else if (spsrWrite && apbBank == bankIndex'(i)) begin
          spsr[i] <= writeWord;
        end
      end
    end
  end

  // One-cycle entry report
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      exceptionTaken <= 1'b0;
      vectorAddress <= '0;
    end else begin
      exceptionTaken <= takeException;
      vectorAddress <= takeException ? targetVector : '0;
    end
  end

  // Read data for CPSR and SPSR addresses
  always_comb begin
    cpsrRdata = '0;
    if (paddr == `ADDR_CPSR) begin
      cpsrRdata[`PSR_WIDTH-1:0] = cpsr;
    end else if (apbBankValid) begin
      cpsrRdata[`PSR_WIDTH-1:0] = spsr[apbBank];
    end
  end

endmodule

`default_nettype wire

// ==== logic/interruptController.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "psr_settings.svh"

module interruptController (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  irqSel,
  input  logic                  pwrite,
  input  logic [`IRQ_LINES-1:0] irqLines,
  input  psrPkg::apbAddr        paddr,
  input  psrPkg::apbData        pwdata,
  output logic                  irqRequest,
  output logic                  fiqRequest,
  output psrPkg::apbData        irqRdata
);

  logic [`IRQ_LINES-1:0] linesPrev;   // Last sampled line levels
  logic [`IRQ_LINES-1:0] pending;
  logic [`IRQ_LINES-1:0] enable;
  logic [`IRQ_LINES-1:0] fiqSelect;   // One routes the line to FIQ
  logic [`IRQ_LINES-1:0] rising;
  logic [`IRQ_LINES-1:0] clearMask;
  logic [`IRQ_LINES-1:0] active;
  logic enableWrite;
  logic selectWrite;
  logic pendingWrite;

  assign enableWrite = irqSel && pwrite && (paddr == `ADDR_IRQ_ENABLE);
  assign selectWrite = irqSel && pwrite && (paddr == `ADDR_FIQ_SELECT);
  assign pendingWrite = irqSel && pwrite && (paddr == `ADDR_IRQ_PENDING);

  assign rising = irqLines & ~linesPrev;
  assign clearMask = pendingWrite ? pwdata[`IRQ_LINES-1:0] : '0;   // Write one to clear

  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      linesPrev <= '0;
      pending <= '0;
    end else begin
      linesPrev <= irqLines;
      // A new edge beats a clear in the same cycle
      pending <= (pending & ~clearMask) | rising;
    end
  end

  // Enable and FIQ select registers
  always_ff @(posedge clk, posedge reset) begin
    if (reset) begin
      enable <= '0;
      fiqSelect <= '0;
    end else begin
      if (enableWrite) begin
        enable <= pwdata[`IRQ_LINES-1:0];
      end
      if (selectWrite) begin
        fiqSelect <= pwdata[`IRQ_LINES-1:0];
      end
    end
  end

  // Requests straight from the registers
  assign active = pending & enable;
  assign fiqRequest = |(active & fiqSelect);
  assign irqRequest = |(active & ~fiqSelect);

  always_comb begin
    irqRdata = '0;
    case (paddr)
      `ADDR_IRQ_ENABLE: irqRdata[`IRQ_LINES-1:0] = enable;
      `ADDR_IRQ_PENDING: irqRdata[`IRQ_LINES-1:0] = pending;
      `ADDR_FIQ_SELECT: irqRdata[`IRQ_LINES-1:0] = fiqSelect;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/apbSlaveMux.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "psr_settings.svh"

module apbSlaveMux (
  input  logic           psel,
  input  logic           penable,
  input  logic           pwrite,
  input  psrPkg::apbAddr paddr,
  input  psrPkg::apbData pwdata,      // Only for the reserved-bit check
  input  psrPkg::apbData cpsrRdata,
  input  psrPkg::apbData irqRdata,
  output logic           cpsrSel,
  output logic           irqSel,
  output logic           pready,
  output logic           pslverr,
  output psrPkg::apbData prdata
);

  logic access;
  logic cpsrHit;
  logic irqHit;
  logic reservedWrite;

  assign access = psel && penable;    // Second APB cycle

  // CPSR and SPSRs from 00 to 14, word aligned
  assign cpsrHit = (paddr[1:0] == 2'b00) && (paddr <= `ADDR_SPSR_LAST);
  assign irqHit = (paddr == `ADDR_IRQ_ENABLE) || (paddr == `ADDR_IRQ_PENDING)
                  || (paddr == `ADDR_FIQ_SELECT);

  // Ones above the line bits of the pending register
  assign reservedWrite = pwrite && (paddr == `ADDR_IRQ_PENDING)
                         && (|pwdata[`APB_DATA_WIDTH-1:`IRQ_LINES]);

  assign cpsrSel = access && cpsrHit;
  assign irqSel = access && irqHit && !reservedWrite;   // Rejected write has no effect

  assign pready = access;             // Zero wait
  assign pslverr = access && (!(cpsrHit || irqHit) || reservedWrite);

  always_comb begin
    if (cpsrHit) begin
      prdata = cpsrRdata;
    end else if (irqHit) begin
      prdata = irqRdata;
    end else begin
      prdata = '0;                    // Unmapped
    end
  end

endmodule

`default_nettype wire

// ==== logic/exceptionUnit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "psr_settings.svh"

module exceptionUnit (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  psrPkg::apbAddr        paddr,
  input  psrPkg::apbData        pwdata,
  output psrPkg::apbData        prdata,
  output logic                  pready,
  output logic                  pslverr,
  input  logic                  dataAbort,
  input  logic                  prefetchAbort,
  input  logic                  undefinedInstr,
  input  logic                  softwareInt,
  input  logic [3:0]            flagsNext,
  input  logic                  flagsEnable,
  input  logic                  restore,
  input  logic [`IRQ_LINES-1:0] irqLines,
  output psrPkg::statusWord     cpsr,
  output logic                  exceptionTaken,
  output psrPkg::vectorOffset   vectorAddress
);
  import psrPkg::*;

  logic irqRequest;
  logic fiqRequest;
  logic takeException;
  modeCode targetMode;
  bankIndex targetBank;
  vectorOffset targetVector;
  logic cpsrSel;
  logic irqSel;
  apbData cpsrRdata;
  apbData irqRdata;

  // Request ranking against current CPSR
  exceptionPrioritizer prioritizer_i (
    .dataAbort(dataAbort),
    .fiqRequest(fiqRequest),
    .irqRequest(irqRequest),
    .prefetchAbort(prefetchAbort),
    .undefinedInstr(undefinedInstr),
    .softwareInt(softwareInt),
    .currentPsr(cpsr),
    .takeException(takeException),
    .targetMode(targetMode),
    .targetBank(targetBank),
    .targetVector(targetVector)
  );

  statusRegisters status_i (
    .clk(clk),
    .reset(reset),
    .takeException(takeException),
    .restore(restore),
    .flagsEnable(flagsEnable),
    .cpsrSel(cpsrSel),
    .pwrite(pwrite),
    .targetMode(targetMode),
    .targetBank(targetBank),
    .targetVector(targetVector),
    .flagsNext(flagsNext),
    .paddr(paddr),
    .pwdata(pwdata),
    .cpsr(cpsr),
    .cpsrRdata(cpsrRdata),
    .exceptionTaken(exceptionTaken),
    .vectorAddress(vectorAddress)
  );

  interruptController irqCtrl_i (
    .clk(clk),
    .reset(reset),
    .irqSel(irqSel),
    .pwrite(pwrite),
    .irqLines(irqLines),
    .paddr(paddr),
    .pwdata(pwdata),
    .irqRequest(irqRequest),
    .fiqRequest(fiqRequest),
    .irqRdata(irqRdata)
  );

  // Single APB port shared by both register blocks
  apbSlaveMux apbMux_i (
    .psel(psel),
    .penable(penable),
    .pwrite(pwrite),
    .paddr(paddr),
    .pwdata(pwdata),
    .cpsrRdata(cpsrRdata),
    .irqRdata(irqRdata),
    .cpsrSel(cpsrSel),
    .irqSel(irqSel),
    .pready(pready),
    .pslverr(pslverr),
    .prdata(prdata)
  );

endmodule

`default_nettype wire

// ==== verification/exceptionUnitTb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "psr_settings.svh"

module exceptionUnitTb;
  import psrPkg::*;

  localparam int apbTimeout = 8;       // Cycles to wait for pready
  localparam int takenTimeout = 20;    // Cycles to wait for exception entry
  localparam int quietCycles = 4;      // Window that must stay free of entries

  // Row operations of the stimulus table
  typedef enum logic [3:0] {
    opRead, opWrite, opPulse, opLines, opRestore, opFlags, opCpsr, opQuiet, opTaken
  } rowOp;

  typedef struct {
    int testId;
    rowOp op;
    apbAddr addr;
    apbData data;
    apbData expected;                  // Read data, vector or CPSR word
  } tableRow;

  logic clk = 1'b0;
  logic reset;
  logic psel;
  logic penable;
  logic pwrite;
  apbAddr paddr;
  apbData pwdata;
  apbData prdata;
  logic pready;
  logic pslverr;
  logic dataAbort;
  logic prefetchAbort;
  logic undefinedInstr;
  logic softwareInt;
  logic [3:0] flagsNext;
  logic flagsEnable;
  logic restore;
  logic [`IRQ_LINES-1:0] irqLines;
  statusWord cpsr;
  logic exceptionTaken;
  vectorOffset vectorAddress;

  tableRow rows [$];
  string testName [1:7];
  logic [31:0] lfsrState;
  int errorCount = 0;
  int checkCount = 0;
  int testErrors = 0;
  int testsRun = 0;

  exceptionUnit dut_i (.*);

  always #10 clk = ~clk;               // 20 ns period

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Error response expected from the register map
  function automatic logic errorExpected(input logic write, input apbAddr a, input apbData d);
    logic mapped;
    mapped = ((a[1:0] == 2'b00) && (a <= `ADDR_SPSR_LAST)) || (a == `ADDR_IRQ_ENABLE)
             || (a == `ADDR_IRQ_PENDING) || (a == `ADDR_FIQ_SELECT);
    return !mapped || (write && (a == `ADDR_IRQ_PENDING) && (|d[31:`IRQ_LINES]));
  endfunction

  task automatic addRow(input int id, input rowOp op, input apbAddr a, input apbData d,
                        input apbData e);
    tableRow r;
    r.testId = id;
    r.op = op;
    r.addr = a;
    r.data = d;
    r.expected = e;
    rows.push_back(r);
  endtask

  task automatic checkValue(input string name, input apbData actual, input apbData expected);
    checkCount++;
    if (actual !== expected) begin
      $display("Mismatch %s: got %h, expected %h", name, actual, expected);
      errorCount++;
      testErrors++;
    end
  endtask

  task automatic noteFailure(input string what);
    $display("Error: %s", what);
    errorCount++;
    testErrors++;
  endtask

  // Setup cycle, then access until pready
  task automatic apbTransfer(input logic write, input apbAddr a, input apbData d,
                             output apbData rdata);
    int waitCount;
    @(posedge clk);
    psel <= 1'b1;
    penable <= 1'b0;
    pwrite <= write;
    paddr <= a;
    pwdata <= d;
    @(posedge clk);
    penable <= 1'b1;
    waitCount = 0;
    @(negedge clk);
    while (!pready && waitCount < apbTimeout) begin
      @(negedge clk);
      waitCount++;
    end
    if (!pready) noteFailure("APB access never saw pready");
    rdata = prdata;
    checkValue("pslverr", apbData'(pslverr), apbData'(errorExpected(write, a, d)));
    @(posedge clk);                    // Access edge
    psel <= 1'b0;
    penable <= 1'b0;
    pwrite <= 1'b0;
  endtask

  // Entry within limit extra cycles, then a report of one cycle only
  task automatic waitTaken(input apbData vector, input int limit);
    int waitCount;
    waitCount = 0;
    @(negedge clk);
    while (!exceptionTaken && waitCount < limit) begin
      @(negedge clk);
      waitCount++;
    end
    if (exceptionTaken) begin
      checkValue("vectorAddress", apbData'(vectorAddress), vector);
      @(negedge clk);
      checkValue("exceptionTaken", apbData'(exceptionTaken), 32'h0);   // Dropped again
    end else begin
      noteFailure($sformatf("no exception was taken within %0d cycles", limit + 1));
    end
  endtask

  // Four bits, one LFSR step each
  task automatic drawFlags(output logic [3:0] f);
    f = '0;
    for (int b = 0; b < 4; b++) begin
      lfsrState = lfsrStep(lfsrState);
      f = {f[2:0], lfsrState[0]};
    end
  endtask

  task automatic finishTest(input int id);
    testsRun++;
    if (testErrors == 0) $display("Test %0d %s: passed", id, testName[id]);
    else $display("Test %0d %s: failed with %0d errors", id, testName[id], testErrors);
    testErrors = 0;
  endtask

  task automatic buildTable();
    testName[1] = "reset values";
    testName[2] = "host write and flag update";
    testName[3] = "data abort entry";
    testName[4] = "masked then taken IRQ";
    testName[5] = "restore and pending clear";
    testName[6] = "FIQ entry";
    testName[7] = "unmapped access";
    addRow(1, opCpsr, '0, '0, 32'h0D3);
    addRow(1, opRead, `ADDR_CPSR, '0, 32'h0D3);
    addRow(1, opRead, 6'h04, '0, 32'h0);           // Svc bank
    addRow(1, opRead, 6'h08, '0, 32'h0);
    addRow(1, opRead, 6'h0C, '0, 32'h0);
    addRow(1, opRead, 6'h10, '0, 32'h0);
    addRow(1, opRead, 6'h14, '0, 32'h0);           // Fiq bank
    addRow(1, opQuiet, '0, '0, '0);
    addRow(2, opWrite, `ADDR_CPSR, 32'h030, '0);    // Usr, reserved bit set
    addRow(2, opRead, `ADDR_CPSR, '0, 32'h010);     // Reserved bit reads zero
    addRow(2, opFlags, '0, 32'h010, '0);
    addRow(2, opFlags, '0, 32'h010, '0);
    addRow(3, opWrite, `ADDR_CPSR, 32'h510, '0);
    addRow(3, opPulse, '0, 32'b1010, 32'h10);       // Data abort beats undefined
    addRow(3, opCpsr, '0, '0, 32'h597);             // Abt, I set, flags kept
    addRow(3, opRead, 6'h08, '0, 32'h510);          // SPSR_abt
    addRow(4, opWrite, `ADDR_CPSR, 32'h090, '0);    // Usr, I set
    addRow(4, opWrite, `ADDR_IRQ_ENABLE, 32'h01, '0);
    addRow(4, opLines, '0, 32'h01, '0);
    addRow(4, opRead, `ADDR_IRQ_PENDING, '0, 32'h01);
    addRow(4, opQuiet, '0, '0, '0);
    addRow(4, opWrite, `ADDR_CPSR, 32'h010, '0);    // Unmask IRQ
    addRow(4, opTaken, '0, '0, 32'h18);
    addRow(4, opCpsr, '0, '0, 32'h092);
    addRow(4, opRead, 6'h10, '0, 32'h010);          // SPSR_irq
    addRow(5, opWrite, `ADDR_IRQ_PENDING, 32'h01, '0);
    addRow(5, opRead, `ADDR_IRQ_PENDING, '0, 32'h00);
    addRow(5, opRestore, '0, '0, '0);
    addRow(5, opCpsr, '0, '0, 32'h010);
    addRow(5, opQuiet, '0, '0, '0);                 // Line still high, no new edge
    addRow(5, opLines, '0, 32'h00, '0);
    addRow(6, opWrite, `ADDR_FIQ_SELECT, 32'h02, '0);
    addRow(6, opWrite, `ADDR_IRQ_ENABLE, 32'h02, '0);
    addRow(6, opLines, '0, 32'h02, '0);
    addRow(6, opTaken, '0, '0, 32'h1C);
    addRow(6, opCpsr, '0, '0, 32'h0D1);             // Fiq, I and F set
    addRow(6, opRead, 6'h14, '0, 32'h010);          // SPSR_fiq
    addRow(6, opLines, '0, 32'h00, '0);
    addRow(7, opRead, 6'h30, '0, 32'h0);
    addRow(7, opRead, 6'h18, '0, 32'h0);            // Gap between banks and IRQ block
    addRow(7, opWrite, `ADDR_IRQ_PENDING, 32'h102, '0);   // Would clear line 1 if taken
    addRow(7, opRead, `ADDR_IRQ_PENDING, '0, 32'h02);   // Rejected write left it
  endtask

  initial begin
    tableRow row;
    int currentTest;
    apbData rdata;
    logic [3:0] flags;
    reset = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    dataAbort = 1'b0;
    prefetchAbort = 1'b0;
    undefinedInstr = 1'b0;
    softwareInt = 1'b0;
    flagsNext = '0;
    flagsEnable = 1'b0;
    restore = 1'b0;
    irqLines = '0;
    lfsrState = 32'h47ca;
    currentTest = 0;
    buildTable();
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      row = rows[i];
      if (row.testId != currentTest) begin
        if (currentTest != 0) finishTest(currentTest);
        currentTest = row.testId;
      end
      case (row.op)
        opRead: begin
          apbTransfer(1'b0, row.addr, '0, rdata);
          checkValue("prdata", rdata, row.expected);
        end
        opWrite: apbTransfer(1'b1, row.addr, row.data, rdata);
        opPulse: begin
          @(posedge clk);
          dataAbort <= row.data[3];
          prefetchAbort <= row.data[2];
          undefinedInstr <= row.data[1];
          softwareInt <= row.data[0];
          @(posedge clk);                          // Taken on this edge
          dataAbort <= 1'b0;
          prefetchAbort <= 1'b0;
          undefinedInstr <= 1'b0;
          softwareInt <= 1'b0;
          waitTaken(row.expected, 0);              // Report due in the next cycle
        end
        opTaken: waitTaken(row.expected, takenTimeout);
        opLines: begin
          @(posedge clk);
          irqLines <= row.data[`IRQ_LINES-1:0];
          @(posedge clk);                          // Pending bit set here
        end
        opRestore: begin
          @(posedge clk);
          restore <= 1'b1;
          @(posedge clk);
          restore <= 1'b0;
        end
        opFlags: begin
          drawFlags(flags);
          @(posedge clk);
          flagsNext <= flags;
          flagsEnable <= 1'b1;
          @(posedge clk);
          flagsEnable <= 1'b0;
          @(negedge clk);
          checkValue("cpsr", apbData'(cpsr), apbData'({flags, row.data[7:0]}));
        end
        opCpsr: begin
          @(negedge clk);
          checkValue("cpsr", apbData'(cpsr), row.expected);
        end
        default: begin
          repeat (quietCycles) begin
            @(negedge clk);
            checkValue("exceptionTaken", apbData'(exceptionTaken), 32'h0);
          end
        end
      endcase
    end
    finishTest(currentTest);
    $display("Tests: %0d, checks: %0d, errors: %0d", testsRun, checkCount, errorCount);
    if (errorCount == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
logic/psrPkg.sv
logic/exceptionPrioritizer.sv
logic/statusRegisters.sv
logic/interruptController.sv
logic/apbSlaveMux.sv
logic/exceptionUnit.sv
verification/exceptionUnitTb.sv

// ==== Makefile ====
TOP := exceptionUnitTb
SOURCES := src.f $(wildcard include/*.svh logic/*.sv verification/*.sv)

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

obj_dir/V$(TOP): $(SOURCES)
	verilator --binary --timing -f src.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
